//--- hdl/dmm_ctl_pkg.sv
// layout of the 29-bit switch control vector and the output mode codes
// shared by the pattern sources, the mode selector and the top-level pin split
package dmm_ctl_pkg;

  // width of the switch control vector
  localparam int NUM_BITS = 29;

  typedef logic [NUM_BITS-1:0] ctl_vec_t;

  //////////////////////////////////////////////////////////////////////
  // field start positions, lsb first
  localparam int IDX_AZMUX         = 0;
  localparam int IDX_HIMUX         = 4;
  localparam int IDX_HIMUX2        = 8;
  localparam int IDX_SIG_PC_SW     = 12;
  localparam int IDX_LED0          = 13;
  localparam int IDX_MONITOR       = 14;
  localparam int IDX_ADCMUX        = 22;
  localparam int IDX_CMPR_LATCH    = 26;
  localparam int IDX_MEAS_COMPLETE = 27;
  localparam int IDX_SPI_INTERRUPT = 28;

  // widths of the multi-bit fields
  localparam int W_AZMUX   = 4;
  localparam int W_HIMUX   = 4;
  localparam int W_HIMUX2  = 4;
  localparam int W_MONITOR = 8;
  localparam int W_ADCMUX  = 4;

  //////////////////////////////////////////////////////////////////////
  // output source, codes 6 and 7 fall back to zero
  typedef enum logic [2:0] {
    MODE_ZERO      = 3'd0,
    MODE_ONES      = 3'd1,
    MODE_COUNT     = 3'd2,
    MODE_DIRECT    = 3'd3,
    MODE_ALTERNATE = 3'd4,
    MODE_AZ        = 3'd5
  } mode_t;

  // azmux code for the zero reference: enable set, input 3
  localparam logic [W_AZMUX-1:0] AZMUX_ZERO_REF = 4'b1011;

endpackage

//--- hdl/spi_reg_pkg.sv
// host interface constants for the spi register bank
// frame layout is one address byte then 32 data bits, msb first
package spi_reg_pkg;

  // register and address widths
  localparam int REG_W  = 32;
  localparam int ADDR_W = 8;

  // full write frame, address then data
  localparam int FRAME_BITS = ADDR_W + REG_W;

  typedef logic [REG_W-1:0] reg_t;

  //////////////////////////////////////////////////////////////////////
  // register map

  // scratch register, readback only
  localparam logic [ADDR_W-1:0] REG_LED     = 8'd1;

  // output mode select, low 3 bits used
  localparam logic [ADDR_W-1:0] REG_MODE    = 8'd3;

  // direct switch value, also the first alternation value
  localparam logic [ADDR_W-1:0] REG_DIRECT  = 8'd4;

  // second alternation value
  localparam logic [ADDR_W-1:0] REG_DIRECT2 = 8'd5;

endpackage

//--- hdl/spi_regs.sv
// spi slave sampled in the clk domain, with the host register bank
// a 40-bit frame writes the addressed register when cs rises
// miso returns the old register content during the data bits
`timescale 1ns/100ps

module spi_regs #(
  parameter int VEC_W = 29
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             spi_sclk,
  input  logic             spi_cs,
  input  logic             spi_mosi,
  output logic             spi_miso,
  output logic [2:0]       reg_mode,
  output logic [VEC_W-1:0] reg_direct,
  output logic [VEC_W-1:0] reg_direct2
);
  import spi_reg_pkg::*;

  // room for a full frame plus saturation
  localparam int CNT_W = $clog2(FRAME_BITS + 2);

  //////////////////////////////////////////////////////////////////////
  // input synchronizers
  // bit 0 metastable, bit 1 synced, bit 2 previous for edge detect
  logic [2:0] sclk_sr;
  logic [2:0] cs_sr;
  logic [1:0] mosi_sr;

  logic sclk_rise;
  logic sclk_fall;
  logic cs_active;
  logic cs_rise;
  logic mosi_s;

  // frame state
  logic [CNT_W-1:0]  bit_cnt;
  logic [ADDR_W-1:0] addr_sr;
  logic [ADDR_W-1:0] addr_next;
  logic              in_data;
  reg_t              data_sr;
  reg_t              rd_sr;
  reg_t              rd_data;

  // register bank
  reg_t led_q;
  reg_t mode_q;
  reg_t direct_q;
  reg_t direct2_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_sr <= '0;
      // cs idles high, so start high to avoid a false edge
      cs_sr   <= '1;
      mosi_sr <= '0;
    end
    else
    begin
      sclk_sr <= {sclk_sr[1:0], spi_sclk};
      cs_sr   <= {cs_sr[1:0], spi_cs};
      mosi_sr <= {mosi_sr[0], spi_mosi};
    end
  end

  assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
  assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
  assign cs_active = ~cs_sr[1];
  assign cs_rise   = cs_sr[1] & ~cs_sr[2];
  assign mosi_s    = mosi_sr[1];

  //////////////////////////////////////////////////////////////////////
  // bit counter and address shift
  assign addr_next = {addr_sr[ADDR_W-2:0], mosi_s};
  // data bits still to be shifted out on miso
  assign in_data   = (bit_cnt >= CNT_W'(ADDR_W)) && (bit_cnt < CNT_W'(FRAME_BITS));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      addr_sr <= '0;
    end
    else if (!cs_active)
      bit_cnt <= '0;
    else if (sclk_rise)
    begin
      // saturate so an overlong frame can never wrap back to 40
      if (bit_cnt != '1)
        bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt < CNT_W'(ADDR_W))
        addr_sr <= addr_next;
    end
  end

  // read mux, indexed by the address as it completes
  always_comb
  begin
    case (addr_next)
      REG_LED:     rd_data = led_q;
      REG_MODE:    rd_data = mode_q;
      REG_DIRECT:  rd_data = direct_q;
      REG_DIRECT2: rd_data = direct2_q;
      default:     rd_data = '0;
    endcase
  end

  // data in and readback out
  always_ff @(posedge clk)
  begin
    if (cs_active && sclk_rise && bit_cnt >= CNT_W'(ADDR_W))
      data_sr <= {data_sr[REG_W-2:0], mosi_s};
    // last address bit arrives, capture old content for readback
    if (cs_active && sclk_rise && bit_cnt == CNT_W'(ADDR_W - 1))
      rd_sr <= rd_data;
    else if (cs_active && sclk_fall && in_data)
      rd_sr <= rd_sr << 1;
  end

  // miso moves after each falling sclk during the data bits
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      spi_miso <= 1'b0;
    else if (!cs_active)
      spi_miso <= 1'b0;
    else if (sclk_fall && in_data)
      spi_miso <= rd_sr[REG_W-1];
  end

  //////////////////////////////////////////////////////////////////////
  // register write on cs release, full frames only
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      led_q     <= '0;
      mode_q    <= '0;
      direct_q  <= '0;
      direct2_q <= '0;
    end
    else if (cs_rise && bit_cnt == CNT_W'(FRAME_BITS))
    begin
      case (addr_sr)
        REG_LED:     led_q     <= data_sr;
        REG_MODE:    mode_q    <= data_sr;
        REG_DIRECT:  direct_q  <= data_sr;
        REG_DIRECT2: direct2_q <= data_sr;
        default:     ;
      endcase
    end
  end

  // truncate to what each consumer needs
  assign reg_mode    = mode_q[2:0];
  assign reg_direct  = direct_q[VEC_W-1:0];
  assign reg_direct2 = direct2_q[VEC_W-1:0];

endmodule

//--- hdl/pattern_gen.sv
// test pattern sources for the switch vector
// count_vec is a free-running count, alt_vec swaps between the two
// direct values every ALT_DIVIDE cycles
`timescale 1ns/100ps

module pattern_gen #(
  parameter int ALT_DIVIDE = 2000000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dmm_ctl_pkg::ctl_vec_t reg_direct,
  input  dmm_ctl_pkg::ctl_vec_t reg_direct2,
  output dmm_ctl_pkg::ctl_vec_t count_vec,
  output dmm_ctl_pkg::ctl_vec_t alt_vec
);

  localparam int DIV_W = $clog2(ALT_DIVIDE + 1);

  logic [DIV_W-1:0] div_cnt;
  logic             div_hit;
  // 0 loads reg_direct next, 1 loads reg_direct2
  logic             alt_sel;

  //////////////////////////////////////////////////////////////////////
  // free-running count, wraps at 2^29
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      count_vec <= '0;
    else
      count_vec <= count_vec + 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // alternation divider
  // counts 0 .. ALT_DIVIDE-1, so one load every ALT_DIVIDE cycles
  assign div_hit = (div_cnt == DIV_W'(ALT_DIVIDE - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (div_hit)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // two-value alternation, starts at 0 and loads reg_direct first
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      alt_sel <= 1'b0;
      alt_vec <= '0;
    end
    else if (div_hit)
    begin
      alt_sel <= ~alt_sel;
      if (alt_sel)
        alt_vec <= reg_direct2;
      else
        alt_vec <= reg_direct;
    end
  end

endmodule

//--- hdl/az_modulator.sv
// auto-zero modulation of the input path
// alternates signal and zero phases of AZ_PERIOD cycles each, driving the
// azmux, pre-charge switch, led and monitor; other fields follow reg_direct
`timescale 1ns/100ps

module az_modulator #(
  parameter int AZ_PERIOD = 20000
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dmm_ctl_pkg::ctl_vec_t reg_direct,
  output dmm_ctl_pkg::ctl_vec_t az_vec
);
  import dmm_ctl_pkg::*;

  localparam int TMR_W = $clog2(AZ_PERIOD + 1);

  logic [TMR_W-1:0] phase_tmr;
  logic             phase_end;
  // 1 in the signal phase, 0 in the zero phase
  logic             sig_phase;
  logic             led_q;

  //////////////////////////////////////////////////////////////////////
  // phase timer
  // reset lands in the zero phase, first signal phase after AZ_PERIOD
  assign phase_end = (phase_tmr == TMR_W'(AZ_PERIOD - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase_tmr <= '0;
      sig_phase <= 1'b0;
      led_q     <= 1'b0;
    end
    else if (phase_end)
    begin
      phase_tmr <= '0;
      sig_phase <= ~sig_phase;
      // blink once per cycle, on entry to the signal phase
      if (!sig_phase)
        led_q <= ~led_q;
    end
    else
    begin
      phase_tmr <= phase_tmr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output vector
  // himux, himux2, adcmux and the top control bits pass straight through
  always_comb
  begin
    az_vec = reg_direct;

    // signal phase keeps the host azmux selection
    // zero phase swaps in the zero reference
    if (!sig_phase)
      az_vec[IDX_AZMUX +: W_AZMUX] = AZMUX_ZERO_REF;

    // pre-charge switch closed during the signal phase
    az_vec[IDX_SIG_PC_SW] = sig_phase;
    az_vec[IDX_LED0]      = led_q;

    // monitor bit 0 shows the phase for the scope
    az_vec[IDX_MONITOR +: W_MONITOR] = {{(W_MONITOR - 1){1'b0}}, sig_phase};
  end

endmodule

//--- hdl/mode_select.sv
// registered output selector for the switch vector
// picks one source by the host mode code, one cycle of latency
`timescale 1ns/100ps

module mode_select (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dmm_ctl_pkg::mode_t    mode,
  input  dmm_ctl_pkg::ctl_vec_t count_vec,
  input  dmm_ctl_pkg::ctl_vec_t alt_vec,
  input  dmm_ctl_pkg::ctl_vec_t direct_vec,
  input  dmm_ctl_pkg::ctl_vec_t az_vec,
  output dmm_ctl_pkg::ctl_vec_t ctl_out
);
  import dmm_ctl_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // eight-way choice
  // zero and all-ones are made here, unused codes 6 and 7 give zero
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ctl_out <= '0;
    else
    begin
      case (mode)
        MODE_ZERO:
          ctl_out <= '0;
        MODE_ONES:
          ctl_out <= '1;
        MODE_COUNT:
          ctl_out <= count_vec;
        MODE_DIRECT:
          ctl_out <= direct_vec;
        MODE_ALTERNATE:
          ctl_out <= alt_vec;
        MODE_AZ:
          ctl_out <= az_vec;
        default:
          ctl_out <= '0;
      endcase
    end
  end

endmodule

//--- hdl/dmm_ctl_top.sv
// voltmeter control core top level
// spi register bank feeding the pattern and auto-zero sources,
// the mode selector picks one and the vector is split into pin groups
`timescale 1ns/100ps

module dmm_ctl_top #(
  parameter int ALT_DIVIDE = 2000000,
  parameter int AZ_PERIOD  = 20000
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       spi_sclk,
  input  logic       spi_cs,
  input  logic       spi_mosi,
  output logic       spi_miso,
  output logic [3:0] azmux,
  output logic [3:0] himux,
  output logic [3:0] himux2,
  output logic       sig_pc_sw,
  output logic       led0,
  output logic [7:0] monitor,
  output logic [3:0] adcmux,
  output logic       cmpr_latch,
  output logic       meas_complete,
  output logic       spi_interrupt
);
  import dmm_ctl_pkg::*;

  logic [2:0] reg_mode;
  ctl_vec_t   reg_direct;
  ctl_vec_t   reg_direct2;
  ctl_vec_t   count_vec;
  ctl_vec_t   alt_vec;
  ctl_vec_t   az_vec;
  ctl_vec_t   ctl_out;

  //////////////////////////////////////////////////////////////////////
  // host registers
  spi_regs #(.VEC_W(NUM_BITS)) i_spi_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .spi_sclk    (spi_sclk),
    .spi_cs      (spi_cs),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .reg_mode    (reg_mode),
    .reg_direct  (reg_direct),
    .reg_direct2 (reg_direct2)
  );

  // count and alternation sources
  pattern_gen #(.ALT_DIVIDE(ALT_DIVIDE)) i_pattern_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .reg_direct  (reg_direct),
    .reg_direct2 (reg_direct2),
    .count_vec   (count_vec),
    .alt_vec     (alt_vec)
  );

  // auto-zero source
  az_modulator #(.AZ_PERIOD(AZ_PERIOD)) i_az_modulator (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_direct (reg_direct),
    .az_vec     (az_vec)
  );

  mode_select i_mode_select (
    .clk        (clk),
    .rst_n      (rst_n),
    .mode       (mode_t'(reg_mode)),
    .count_vec  (count_vec),
    .alt_vec    (alt_vec),
    .direct_vec (reg_direct),
    .az_vec     (az_vec),
    .ctl_out    (ctl_out)
  );

  //////////////////////////////////////////////////////////////////////
  // split the vector into pin groups
  assign azmux         = ctl_out[IDX_AZMUX +: W_AZMUX];
  assign himux         = ctl_out[IDX_HIMUX +: W_HIMUX];
  assign himux2        = ctl_out[IDX_HIMUX2 +: W_HIMUX2];
  assign sig_pc_sw     = ctl_out[IDX_SIG_PC_SW];
  assign led0          = ctl_out[IDX_LED0];
  assign monitor       = ctl_out[IDX_MONITOR +: W_MONITOR];
  assign adcmux        = ctl_out[IDX_ADCMUX +: W_ADCMUX];
  assign cmpr_latch    = ctl_out[IDX_CMPR_LATCH];
  assign meas_complete = ctl_out[IDX_MEAS_COMPLETE];
  assign spi_interrupt = ctl_out[IDX_SPI_INTERRUPT];

endmodule

//--- tests/tb_clk_gen.sv
// clock and reset source for the testbench
// 100 ns clock, reset held low for the first 5 cycles
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int HALF_NS    = 50,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    // release away from the active edge
    @(negedge clk);
    rst_n = 1'b1;
  end

  always #(HALF_NS) clk = ~clk;

endmodule

//--- tests/dmm_ctl_tb.sv
// testbench for the voltmeter control core
// drives spi frames on the falling clk edge and keeps a register model
// checks readback, every output mode and the auto-zero timing
`timescale 1ns/100ps

module dmm_ctl_tb;
  import dmm_ctl_pkg::*;
  import spi_reg_pkg::*;

  // clk cycles per spi frame and for the whole run
  localparam int FRAME_CYC  = 8 * FRAME_BITS + 9;
  localparam int EST_CYCLES = 28 * FRAME_CYC + 800;

  logic       clk, rst_n;
  logic       spi_sclk, spi_cs, spi_mosi, spi_miso;
  logic [3:0] azmux, himux, himux2, adcmux;
  logic       sig_pc_sw, led0, cmpr_latch, meas_complete, spi_interrupt;
  logic [7:0] monitor;
  ctl_vec_t   out_vec;

  reg_t        model_regs [0:255];
  logic [31:0] rng_state = 32'h8c5d;
  string       cur_test;
  int          test_errs, total_errs, tests_run, tests_failed;

  tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

  dmm_ctl_top #(.ALT_DIVIDE(40), .AZ_PERIOD(16)) i_dut (
    .clk(clk), .rst_n(rst_n), .spi_sclk(spi_sclk), .spi_cs(spi_cs),
    .spi_mosi(spi_mosi), .spi_miso(spi_miso), .azmux(azmux), .himux(himux),
    .himux2(himux2), .sig_pc_sw(sig_pc_sw), .led0(led0), .monitor(monitor),
    .adcmux(adcmux), .cmpr_latch(cmpr_latch), .meas_complete(meas_complete),
    .spi_interrupt(spi_interrupt)
  );

  // pin groups joined back into the switch vector
  always_comb
  begin
    out_vec = '0;
    out_vec[IDX_AZMUX +: W_AZMUX]     = azmux;
    out_vec[IDX_HIMUX +: W_HIMUX]     = himux;
    out_vec[IDX_HIMUX2 +: W_HIMUX2]   = himux2;
    out_vec[IDX_SIG_PC_SW]            = sig_pc_sw;
    out_vec[IDX_LED0]                 = led0;
    out_vec[IDX_MONITOR +: W_MONITOR] = monitor;
    out_vec[IDX_ADCMUX +: W_ADCMUX]   = adcmux;
    out_vec[IDX_CMPR_LATCH]           = cmpr_latch;
    out_vec[IDX_MEAS_COMPLETE]        = meas_complete;
    out_vec[IDX_SPI_INTERRUPT]        = spi_interrupt;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  // xorshift32 step
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("Error: %s / %s expected %h actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond === 1'b1)
    else
    begin
      $display("Failure in %s: %s", cur_test, msg);
      test_errs++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errs += test_errs;
    if (test_errs != 0)
      tests_failed++;
    $display("%s %s, %0d errors", (test_errs == 0) ? "[ok]    " : "[FAILED]", cur_test,
             test_errs);
  endtask

  // one frame of nbits with the address and then the data msb first
  // mosi moves while sclk is low
  // miso is sampled at the end of each low half
  task automatic spi_frame(input logic [7:0] addr, input reg_t data, input int nbits,
                           output reg_t rd);
    logic [39:0] frame;
    int          i;
    frame = {addr, data};
    rd    = '0;
    @(negedge clk);
    spi_cs = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      spi_sclk = 1'b0;
      spi_mosi = frame[39 - i];
      repeat (4) @(negedge clk);
      if (i >= ADDR_W)
        rd = {rd[REG_W-2:0], spi_miso};
      spi_sclk = 1'b1;
      repeat (4) @(negedge clk);
    end
    spi_sclk = 1'b0;
    repeat (4) @(negedge clk);
    // a full frame writes when cs rises and shows within 4 cycles
    spi_cs = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  // full write that also checks the old value against the model
  task automatic reg_write(input logic [7:0] addr, input reg_t data);
    reg_t rd;
    spi_frame(addr, data, FRAME_BITS, rd);
    check_eq($sformatf("old value at %0d", addr), model_regs[addr], rd);
    if (addr == REG_LED || addr == REG_MODE || addr == REG_DIRECT || addr == REG_DIRECT2)
      model_regs[addr] = data;
  endtask

  // readback that writes the model value back unchanged
  task automatic reg_read_check(input logic [7:0] addr);
    reg_t rd;
    spi_frame(addr, model_regs[addr], FRAME_BITS, rd);
    check_eq($sformatf("readback at %0d", addr), model_regs[addr], rd);
  endtask

  task automatic set_mode(input logic [2:0] code);
    reg_write(REG_MODE, reg_t'(code));
    repeat (10) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // watchdog
  initial
  begin
    repeat (EST_CYCLES * 3 / 2) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", EST_CYCLES * 3 / 2);
    $display("Test failures found");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  initial
  begin
    ctl_vec_t   a, b, d, prev, exp_vec;
    int         run_len;
    logic       first_run, seen_a, seen_b, prev_sig, prev_led;
    reg_t       rd;
    logic [7:0] map_addrs [4];
    spi_sclk = 1'b0;
    spi_cs   = 1'b1;
    spi_mosi = 1'b0;
    for (int k = 0; k < 256; k++)
      model_regs[k] = '0;
    map_addrs = '{REG_LED, REG_MODE, REG_DIRECT, REG_DIRECT2};
    @(posedge rst_n);
    @(negedge clk);

    // reset state then random writes with readback
    begin_test("reset and readback");
    check_eq("vector after reset", 0, out_vec);
    check_eq("miso after reset", 0, spi_miso);
    foreach (map_addrs[j])
    begin
      reg_write(map_addrs[j], next_rand());
      reg_read_check(map_addrs[j]);
    end
    // unmapped address takes no write and reads 0
    reg_write(8'h20, next_rand());
    reg_read_check(8'h20);
    end_test();

    // fixed modes
    begin_test("fixed modes");
    set_mode(MODE_ZERO);
    check_eq("zero mode", 0, out_vec);
    set_mode(MODE_ONES);
    check_eq("ones mode", {NUM_BITS{1'b1}}, out_vec);
    set_mode(3'd6);
    check_eq("code 6", 0, out_vec);
    set_mode(3'd7);
    check_eq("code 7", 0, out_vec);
    reg_write(REG_DIRECT, next_rand());
    set_mode(MODE_DIRECT);
    check_eq("direct mode", ctl_vec_t'(model_regs[REG_DIRECT]), out_vec);
    end_test();

    // count mode steps by one every sample
    begin_test("count mode");
    set_mode(MODE_COUNT);
    prev = out_vec;
    repeat (50)
    begin
      @(negedge clk);
      check_eq("count step", ctl_vec_t'(prev + 1'b1), out_vec);
      prev = out_vec;
    end
    end_test();

    // alternation between two distinct values in runs of 40 cycles
    begin_test("alternation");
    reg_write(REG_DIRECT, next_rand());
    reg_write(REG_DIRECT2, next_rand());
    a = ctl_vec_t'(model_regs[REG_DIRECT]);
    b = ctl_vec_t'(model_regs[REG_DIRECT2]);
    if (a == b)
    begin
      reg_write(REG_DIRECT2, model_regs[REG_DIRECT2] ^ 32'h1);
      b = ctl_vec_t'(model_regs[REG_DIRECT2]);
    end
    set_mode(MODE_ALTERNATE);
    prev      = out_vec;
    run_len   = 0;
    first_run = 1'b1;
    seen_a    = 1'b0;
    seen_b    = 1'b0;
    repeat (400)
    begin
      @(negedge clk);
      check_true(out_vec == a || out_vec == b, "output is neither direct value");
      seen_a |= (out_vec == a);
      seen_b |= (out_vec == b);
      if (out_vec != prev)
      begin
        if (!first_run)
          check_true(run_len >= 39 && run_len <= 41, "alternation run length out of range");
        first_run = 1'b0;
        run_len   = 1;
      end
      else
        run_len++;
      prev = out_vec;
    end
    check_true(seen_a && seen_b, "alternation did not show both values");
    // the last run must not outlast a full one
    check_true(run_len <= 41, "alternation stopped swapping");
    end_test();

    // auto-zero phases
    begin_test("auto-zero");
    reg_write(REG_DIRECT, next_rand());
    d = ctl_vec_t'(model_regs[REG_DIRECT]);
    set_mode(MODE_AZ);
    prev_sig  = sig_pc_sw;
    prev_led  = led0;
    run_len   = 0;
    first_run = 1'b1;
    repeat (200)
    begin
      @(negedge clk);
      // led is checked on its own below
      exp_vec = d;
      exp_vec[IDX_LED0]                 = led0;
      exp_vec[IDX_SIG_PC_SW]            = sig_pc_sw;
      exp_vec[IDX_MONITOR +: W_MONITOR] = W_MONITOR'(sig_pc_sw);
      if (!sig_pc_sw)
        exp_vec[IDX_AZMUX +: W_AZMUX] = AZMUX_ZERO_REF;
      check_eq(sig_pc_sw ? "signal phase" : "zero phase", exp_vec, out_vec);
      if (sig_pc_sw && !prev_sig)
        check_true(led0 != prev_led, "led did not toggle at signal phase start");
      else
        check_true(led0 == prev_led, "led changed outside a signal phase start");
      if (sig_pc_sw != prev_sig)
      begin
        if (!first_run)
          check_true(run_len >= 15 && run_len <= 17, "auto-zero phase length out of range");
        first_run = 1'b0;
        run_len   = 1;
      end
      else
        run_len++;
      prev_sig = sig_pc_sw;
      prev_led = led0;
    end
    // the phase still running must not be too long either
    check_true(run_len <= 17, "auto-zero phase did not end in time");
    end_test();

    // short frame must not write
    begin_test("aborted frame");
    reg_write(REG_DIRECT2, next_rand());
    spi_frame(REG_DIRECT2, ~model_regs[REG_DIRECT2], 20, rd);
    reg_read_check(REG_DIRECT2);
    end_test();

    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             total_errs);
    if (total_errs == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

//--- dmm_ctl_top.f
hdl/dmm_ctl_pkg.sv
hdl/spi_reg_pkg.sv
hdl/spi_regs.sv
hdl/pattern_gen.sv
hdl/az_modulator.sv
hdl/mode_select.sv
hdl/dmm_ctl_top.sv
tests/tb_clk_gen.sv
tests/dmm_ctl_tb.sv

//--- run.sh
#!/bin/sh
# builds the voltmeter control core testbench with Verilator and runs it
# exit status 0 only when the simulation log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dmm_ctl_tb \
  -f dmm_ctl_top.f -Mdir obj_dir -o dmm_ctl_sim > build.log 2>&1 &&
./obj_dir/dmm_ctl_sim > sim.log 2>&1 ||
echo "build or simulation ended abnormally, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log && echo "result: pass" && exit 0 ||
{ echo "result: fail"; exit 1; }
